//--- Makefile
# Verilator simulation of the chip core
SIM      = verilator
TOP      = tb_chip_core
FILELIST = chip_core.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- chip_core.f
design/axil_pkg.sv
design/chip_map_pkg.sv
design/axil_bus_ctrl.sv
design/ram_main.sv
design/gpio_straps.sv
design/sw_test_status.sv
design/chip_core.sv
tests/tb_chip_core_checker.sv
tests/tb_chip_core.sv

//--- design/axil_bus_ctrl.sv
// AXI4-Lite slave controller
// Runs the handshakes, decodes the chip address map into block selects
// and muxes the block read data back with the response codes
`timescale 1ns/1ns
`default_nettype none

module axil_bus_ctrl (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  // Write address and data
  input  logic [axil_pkg::AXIL_ADDR_W-1:0]       awaddr_i,
  input  logic                                   awvalid_i,
  output logic                                   awready_o,
  input  logic [axil_pkg::AXIL_DATA_W-1:0]       wdata_i,
  input  logic [axil_pkg::AXIL_STRB_W-1:0]       wstrb_i,
  input  logic                                   wvalid_i,
  output logic                                   wready_o,
  // Write response
  output logic [axil_pkg::AXIL_RESP_W-1:0]       bresp_o,
  output logic                                   bvalid_o,
  input  logic                                   bready_i,
  // Read address and data
  input  logic [axil_pkg::AXIL_ADDR_W-1:0]       araddr_i,
  input  logic                                   arvalid_i,
  output logic                                   arready_o,
  output logic [axil_pkg::AXIL_DATA_W-1:0]       rdata_o,
  output logic [axil_pkg::AXIL_RESP_W-1:0]       rresp_o,
  output logic                                   rvalid_o,
  input  logic                                   rready_i,
  // Block side
  output logic                                   ram_we_o,
  output logic [axil_pkg::AXIL_STRB_W-1:0]       ram_wstrb_o,
  output logic [chip_map_pkg::RAM_AW-1:0]        ram_waddr_o,
  output logic [chip_map_pkg::RAM_AW-1:0]        ram_raddr_o,
  output logic [axil_pkg::AXIL_DATA_W-1:0]       ram_wdata_o,
  output logic                                   gpio_we_o,
  output logic [chip_map_pkg::GPIO_OFS_W-1:0]    gpio_rofs_o,
  output logic                                   status_we_o,
  output logic [axil_pkg::AXIL_DATA_W-1:0]       wdata_o,
  input  logic [axil_pkg::AXIL_DATA_W-1:0]       ram_rdata_i,
  input  logic [chip_map_pkg::NUM_GPIOS-1:0]     gpio_rdata_i,
  input  logic [chip_map_pkg::STATUS_W-1:0]      status_rdata_i
);
  import axil_pkg::*;
  import chip_map_pkg::*;

  typedef enum logic [1:0] {
    RGN_NONE,
    RGN_RAM,
    RGN_GPIO,
    RGN_STATUS
  } region_e;

  region_e                wr_rgn;
  region_e                rd_rgn;
  region_e                rd_rgn_q;     // Region of the read in flight
  logic                   wr_go;
  logic                   rd_go;
  logic                   bvalid_q;
  logic                   rvalid_q;
  logic [AXIL_RESP_W-1:0] bresp_q;
  logic [AXIL_RESP_W-1:0] rresp_q;
  logic                   rd_fresh_q;   // First cycle of a read response
  logic [AXIL_DATA_W-1:0] rd_mux;
  logic [AXIL_DATA_W-1:0] rdata_hold_q;

  // Map a byte address onto a block, unlisted GPIO offsets fall through
  function automatic region_e decode(input logic [AXIL_ADDR_W-1:0] addr);
    region_e               rgn;
    logic [GPIO_OFS_W-1:0] ofs;
    rgn = RGN_NONE;
    ofs = addr[GPIO_OFS_W-1:0];
    if (addr[AXIL_ADDR_W-1:RAM_SPAN_W] == RAM_BASE[AXIL_ADDR_W-1:RAM_SPAN_W]) begin
      rgn = RGN_RAM;
    end else if (addr[AXIL_ADDR_W-1:GPIO_OFS_W] == GPIO_BASE[AXIL_ADDR_W-1:GPIO_OFS_W] &&
                 (ofs == GPIO_OUT_OFS || ofs == GPIO_IN_OFS || ofs == GPIO_STRAP_OFS)) begin
      rgn = RGN_GPIO;
    end else if (addr[AXIL_ADDR_W-1:BYTE_OFS_W] == STATUS_BASE[AXIL_ADDR_W-1:BYTE_OFS_W]) begin
      rgn = RGN_STATUS;
    end
    return rgn;
  endfunction

  assign wr_rgn = decode(awaddr_i);
  assign rd_rgn = decode(araddr_i);

  // Address and data taken together, one write in flight
  assign wr_go     = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_go;
  assign wready_o  = wr_go;
  assign rd_go     = arvalid_i & ~rvalid_q; // Held response stalls the AR channel
  assign arready_o = rd_go;

  // Block write strobes land on the accepting edge
  assign ram_we_o    = wr_go && (wr_rgn == RGN_RAM);
  assign gpio_we_o   = wr_go && (wr_rgn == RGN_GPIO) &&
                       (awaddr_i[GPIO_OFS_W-1:0] == GPIO_OUT_OFS); // IN and STRAP ignore writes
  assign status_we_o = wr_go && (wr_rgn == RGN_STATUS);
  assign ram_wstrb_o = wstrb_i;
  assign ram_waddr_o = awaddr_i[RAM_SPAN_W-1:BYTE_OFS_W];
  assign ram_wdata_o = wdata_i;
  assign wdata_o     = wdata_i;  // GPIO and status take full words

  // Reads are registered in the blocks, addressed straight from AR
  assign ram_raddr_o = araddr_i[RAM_SPAN_W-1:BYTE_OFS_W];
  assign gpio_rofs_o = araddr_i[GPIO_OFS_W-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      bresp_q  <= RESP_OKAY;
    end else if (wr_go) begin
      bvalid_q <= 1'b1;
      bresp_q  <= (wr_rgn == RGN_NONE) ? RESP_SLVERR : RESP_OKAY;
    end else if (bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q   <= 1'b0;
      rresp_q    <= RESP_OKAY;
      rd_rgn_q   <= RGN_NONE;
      rd_fresh_q <= 1'b0;
    end else begin
      rd_fresh_q <= rd_go;
      if (rd_go) begin
        rvalid_q <= 1'b1;
        rresp_q  <= (rd_rgn == RGN_NONE) ? RESP_SLVERR : RESP_OKAY;
        rd_rgn_q <= rd_rgn;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Return data by region, zero for unmapped reads
  always_comb begin
    rd_mux = '0;
    case (rd_rgn_q)
      RGN_RAM:    rd_mux = ram_rdata_i;
      RGN_GPIO:   rd_mux[NUM_GPIOS-1:0] = gpio_rdata_i;
      RGN_STATUS: rd_mux[STATUS_W-1:0] = status_rdata_i;
      default:    rd_mux = '0;
    endcase
  end

  // Block outputs move on, so freeze the word while the host stalls
  always_ff @(posedge clk_i) begin
    if (rd_fresh_q) begin
      rdata_hold_q <= rd_mux;
    end
  end

  assign rdata_o  = rd_fresh_q ? rd_mux : rdata_hold_q;
  assign rresp_o  = rresp_q;
  assign rvalid_o = rvalid_q;
  assign bresp_o  = bresp_q;
  assign bvalid_o = bvalid_q;

endmodule

`default_nettype wire

//--- design/axil_pkg.sv
// AXI4-Lite protocol constants
// Bus widths and response encodings
`default_nettype none

package axil_pkg;

  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8; // One strobe per byte lane
  localparam int AXIL_RESP_W = 2;

  // xRESP encodings
  localparam logic [AXIL_RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [AXIL_RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- design/chip_core.sv
// Chip core top level
// AXI4-Lite host port onto the bus controller, RAM, GPIO and test status
`timescale 1ns/1ns
`default_nettype none

module chip_core (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [axil_pkg::AXIL_ADDR_W-1:0]      awaddr_i,
  input  logic                                  awvalid_i,
  output logic                                  awready_o,
  input  logic [axil_pkg::AXIL_DATA_W-1:0]      wdata_i,
  input  logic [axil_pkg::AXIL_STRB_W-1:0]      wstrb_i,
  input  logic                                  wvalid_i,
  output logic                                  wready_o,
  output logic [axil_pkg::AXIL_RESP_W-1:0]      bresp_o,
  output logic                                  bvalid_o,
  input  logic                                  bready_i,
  input  logic [axil_pkg::AXIL_ADDR_W-1:0]      araddr_i,
  input  logic                                  arvalid_i,
  output logic                                  arready_o,
  output logic [axil_pkg::AXIL_DATA_W-1:0]      rdata_o,
  output logic [axil_pkg::AXIL_RESP_W-1:0]      rresp_o,
  output logic                                  rvalid_o,
  input  logic                                  rready_i,
  // Pins
  input  logic [chip_map_pkg::NUM_GPIOS-1:0]    gpio_i,
  output logic [chip_map_pkg::NUM_GPIOS-1:0]    gpio_o,
  input  logic [chip_map_pkg::NUM_STRAPS-1:0]   sw_straps_i,
  output logic                                  test_done_o,
  output logic                                  test_passed_o
);
  import axil_pkg::*;
  import chip_map_pkg::*;

  logic                   ram_we;
  logic [AXIL_STRB_W-1:0] ram_wstrb;
  logic [RAM_AW-1:0]      ram_waddr;
  logic [RAM_AW-1:0]      ram_raddr;
  logic [AXIL_DATA_W-1:0] ram_wdata;
  logic [AXIL_DATA_W-1:0] ram_rdata;
  logic                   gpio_we;
  logic [GPIO_OFS_W-1:0]  gpio_rofs;
  logic [NUM_GPIOS-1:0]   gpio_rdata;
  logic                   status_we;
  logic [STATUS_W-1:0]    status_rdata;
  logic [AXIL_DATA_W-1:0] bus_wdata;    // Shared by GPIO and status

  axil_bus_ctrl u_bus_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .awaddr_i       (awaddr_i),
    .awvalid_i      (awvalid_i),
    .awready_o      (awready_o),
    .wdata_i        (wdata_i),
    .wstrb_i        (wstrb_i),
    .wvalid_i       (wvalid_i),
    .wready_o       (wready_o),
    .bresp_o        (bresp_o),
    .bvalid_o       (bvalid_o),
    .bready_i       (bready_i),
    .araddr_i       (araddr_i),
    .arvalid_i      (arvalid_i),
    .arready_o      (arready_o),
    .rdata_o        (rdata_o),
    .rresp_o        (rresp_o),
    .rvalid_o       (rvalid_o),
    .rready_i       (rready_i),
    .ram_we_o       (ram_we),
    .ram_wstrb_o    (ram_wstrb),
    .ram_waddr_o    (ram_waddr),
    .ram_raddr_o    (ram_raddr),
    .ram_wdata_o    (ram_wdata),
    .gpio_we_o      (gpio_we),
    .gpio_rofs_o    (gpio_rofs),
    .status_we_o    (status_we),
    .wdata_o        (bus_wdata),
    .ram_rdata_i    (ram_rdata),
    .gpio_rdata_i   (gpio_rdata),
    .status_rdata_i (status_rdata)
  );

  ram_main u_ram (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .wstrb_i (ram_wstrb),
    .waddr_i (ram_waddr),
    .raddr_i (ram_raddr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  gpio_straps u_gpio (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .we_i        (gpio_we),
    .wdata_i     (bus_wdata[NUM_GPIOS-1:0]), // Low lanes carry the pin value
    .rofs_i      (gpio_rofs),
    .gpio_i      (gpio_i),
    .sw_straps_i (sw_straps_i),
    .gpio_o      (gpio_o),
    .rdata_o     (gpio_rdata)
  );

  sw_test_status u_status (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .we_i          (status_we),
    .wdata_i       (bus_wdata[STATUS_W-1:0]),
    .rdata_o       (status_rdata),
    .test_done_o   (test_done_o),
    .test_passed_o (test_passed_o)
  );

endmodule

`default_nettype wire

//--- design/chip_map_pkg.sv
// Chip address map
// Base addresses, RAM geometry, GPIO and strap widths, test-status codes
`default_nettype none

package chip_map_pkg;

  // Main RAM, word addressed behind a byte address
  localparam logic [31:0] RAM_BASE   = 32'h0000_0000;
  localparam int          RAM_WORDS  = 256;
  localparam int          RAM_AW     = 8;
  localparam int          BYTE_OFS_W = 2;                  // Byte lane bits of a word
  localparam int          RAM_SPAN_W = RAM_AW + BYTE_OFS_W; // Bytes covered by the RAM

  // GPIO block, 16 byte window
  localparam logic [31:0]           GPIO_BASE      = 32'h0001_0000;
  localparam int                    GPIO_OFS_W     = 4;
  localparam logic [GPIO_OFS_W-1:0] GPIO_OUT_OFS   = 4'h0; // Read-write
  localparam logic [GPIO_OFS_W-1:0] GPIO_IN_OFS    = 4'h4; // Read-only
  localparam logic [GPIO_OFS_W-1:0] GPIO_STRAP_OFS = 4'h8; // Read-only
  localparam int                    NUM_GPIOS      = 16;
  localparam int                    NUM_STRAPS     = 3;

  // Software test status, a single word
  localparam logic [31:0]         STATUS_BASE = 32'h0002_0000;
  localparam int                  STATUS_W    = 16;
  localparam logic [STATUS_W-1:0] ST_PASSED   = 16'h900D;
  localparam logic [STATUS_W-1:0] ST_FAILED   = 16'hBAAD;

endpackage

`default_nettype wire

//--- design/gpio_straps.sv
// GPIO and boot straps
// Output register, synchronized inputs, strap capture at reset release
// and a registered read mux by register offset
`timescale 1ns/1ns
`default_nettype none

module gpio_straps (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  we_i,
  input  logic [chip_map_pkg::NUM_GPIOS-1:0]    wdata_i,
  input  logic [chip_map_pkg::GPIO_OFS_W-1:0]   rofs_i,
  input  logic [chip_map_pkg::NUM_GPIOS-1:0]    gpio_i,
  input  logic [chip_map_pkg::NUM_STRAPS-1:0]   sw_straps_i,
  output logic [chip_map_pkg::NUM_GPIOS-1:0]    gpio_o,
  output logic [chip_map_pkg::NUM_GPIOS-1:0]    rdata_o
);
  import chip_map_pkg::*;

  logic [NUM_GPIOS-1:0]  gpio_out_q;
  logic [NUM_GPIOS-1:0]  sync1_q;       // Metastability stage
  logic [NUM_GPIOS-1:0]  sync2_q;
  logic [NUM_STRAPS-1:0] straps_q;
  logic                  straps_vld_q;  // Straps taken since reset
  logic [NUM_GPIOS-1:0]  rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gpio_out_q   <= '0;
      straps_q     <= '0;
      straps_vld_q <= 1'b0;
    end else begin
      if (we_i) begin
        gpio_out_q <= wdata_i;
      end
      // First edge out of reset only
      if (!straps_vld_q) begin
        straps_q     <= sw_straps_i;
        straps_vld_q <= 1'b1;
      end
    end
  end

  // Pins are asynchronous to clk_i
  always_ff @(posedge clk_i) begin
    sync1_q <= gpio_i;
    sync2_q <= sync1_q;
  end

  always_ff @(posedge clk_i) begin
    case (rofs_i)
      GPIO_OUT_OFS:   rdata_q <= gpio_out_q;
      GPIO_IN_OFS:    rdata_q <= sync2_q;
      GPIO_STRAP_OFS: rdata_q <= {{(NUM_GPIOS - NUM_STRAPS){1'b0}}, straps_q};
      default:        rdata_q <= '0;
    endcase
  end

  assign gpio_o  = gpio_out_q;
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- design/ram_main.sv
// Main RAM
// Word array with byte-strobed writes and a registered one-cycle read
`timescale 1ns/1ns
`default_nettype none

module ram_main (
  input  logic                                clk_i,
  input  logic                                we_i,
  input  logic [axil_pkg::AXIL_STRB_W-1:0]    wstrb_i,
  input  logic [chip_map_pkg::RAM_AW-1:0]     waddr_i,
  input  logic [chip_map_pkg::RAM_AW-1:0]     raddr_i,
  input  logic [axil_pkg::AXIL_DATA_W-1:0]    wdata_i,
  output logic [axil_pkg::AXIL_DATA_W-1:0]    rdata_o
);
  import axil_pkg::*;
  import chip_map_pkg::*;

  logic [AXIL_DATA_W-1:0] mem_q [RAM_WORDS];
  logic [AXIL_DATA_W-1:0] rdata_q;

  // Only enabled byte lanes change
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read sees the word before a same-edge write
  always_ff @(posedge clk_i) begin
    rdata_q <= mem_q[raddr_i];
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- design/sw_test_status.sv
// Software test status
// Holds the last status code and raises sticky done and passed flags
`timescale 1ns/1ns
`default_nettype none

module sw_test_status (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                we_i,
  input  logic [chip_map_pkg::STATUS_W-1:0]   wdata_i,
  output logic [chip_map_pkg::STATUS_W-1:0]   rdata_o,
  output logic                                test_done_o,
  output logic                                test_passed_o
);
  import chip_map_pkg::*;

  logic [STATUS_W-1:0] code_q;
  logic                done_q;
  logic                passed_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      code_q   <= '0;
      done_q   <= 1'b0;
      passed_q <= 1'b0;
    end else if (we_i) begin
      code_q <= wdata_i; // Any code is kept for read-back
      if (wdata_i == ST_PASSED) begin
        done_q   <= 1'b1;
        passed_q <= 1'b1;
      end else if (wdata_i == ST_FAILED) begin
        done_q <= 1'b1;  // Done without passed
      end
    end
  end

  // Flags stay up until the next reset
  assign rdata_o       = code_q;
  assign test_done_o   = done_q;
  assign test_passed_o = passed_q;

endmodule

`default_nettype wire

//--- tests/tb_chip_core.sv
// Chip core testbench
// Stub AXI4-Lite host against a reference model of the chip address map
`timescale 1ns/1ns
`default_nettype none

module tb_chip_core;
  import axil_pkg::*;
  import chip_map_pkg::*;

  localparam int          TIMEOUT_CYC = 64;
  localparam int          RAM_TESTS   = 16;
  localparam logic [31:0] SEED        = 32'h377eebf0;

  logic                   clk_i;
  logic                   rst_n_i;
  logic [AXIL_ADDR_W-1:0] awaddr_i;
  logic                   awvalid_i;
  logic                   awready_o;
  logic [AXIL_DATA_W-1:0] wdata_i;
  logic [AXIL_STRB_W-1:0] wstrb_i;
  logic                   wvalid_i;
  logic                   wready_o;
  logic [AXIL_RESP_W-1:0] bresp_o;
  logic                   bvalid_o;
  logic                   bready_i;
  logic [AXIL_ADDR_W-1:0] araddr_i;
  logic                   arvalid_i;
  logic                   arready_o;
  logic [AXIL_DATA_W-1:0] rdata_o;
  logic [AXIL_RESP_W-1:0] rresp_o;
  logic                   rvalid_o;
  logic                   rready_i;
  logic [NUM_GPIOS-1:0]   gpio_i;
  logic [NUM_GPIOS-1:0]   gpio_o;
  logic [NUM_STRAPS-1:0]  sw_straps_i;
  logic                   test_done_o;
  logic                   test_passed_o;

  // Reference state of the chip
  logic [AXIL_DATA_W-1:0] ref_mem [RAM_WORDS];
  logic [NUM_GPIOS-1:0]   ref_gpio_out;
  logic [NUM_STRAPS-1:0]  ref_straps;
  logic [STATUS_W-1:0]    ref_status;
  string                  name_q[$];    // Pending checks as {resp, data}
  logic [33:0]            exp_q[$];
  logic [33:0]            act_q[$];
  int                     check_cnt;
  int                     err_cnt;
  int                     test_checks;  // Counts at the start of a test
  int                     test_errs;

  chip_core DUT (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] gpio_addr(input logic [GPIO_OFS_W-1:0] ofs);
    return {GPIO_BASE[AXIL_ADDR_W-1:GPIO_OFS_W], ofs};
  endfunction

  // Expected {resp, data} of a read
  function automatic logic [33:0] expect_read(input logic [31:0] addr);
    if (addr < RAM_WORDS * 4) return {RESP_OKAY, ref_mem[addr[RAM_AW+1:2]]};
    if (addr == gpio_addr(GPIO_OUT_OFS)) return {RESP_OKAY, 16'h0, ref_gpio_out};
    if (addr == gpio_addr(GPIO_IN_OFS)) return {RESP_OKAY, 16'h0, gpio_i}; // Settled pins
    if (addr == gpio_addr(GPIO_STRAP_OFS)) return {RESP_OKAY, 29'h0, ref_straps};
    if ((addr >> 2) == (STATUS_BASE >> 2)) return {RESP_OKAY, 16'h0, ref_status};
    return {RESP_SLVERR, 32'h0};
  endfunction

  // Applies a write to the model and returns the expected bresp
  function automatic logic [1:0] model_write(input logic [31:0] addr, input logic [31:0] data,
                                             input logic [3:0] strb);
    if (addr < RAM_WORDS * 4) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (strb[b]) ref_mem[addr[RAM_AW+1:2]][8*b +: 8] = data[8*b +: 8];
      end
      return RESP_OKAY;
    end
    if (addr == gpio_addr(GPIO_OUT_OFS)) ref_gpio_out = data[NUM_GPIOS-1:0];
    if (addr == gpio_addr(GPIO_OUT_OFS) || addr == gpio_addr(GPIO_IN_OFS) ||
        addr == gpio_addr(GPIO_STRAP_OFS)) return RESP_OKAY;
    if ((addr >> 2) == (STATUS_BASE >> 2)) begin
      ref_status = data[STATUS_W-1:0];
      return RESP_OKAY;
    end
    return RESP_SLVERR; // Nothing mapped there
  endfunction

  task automatic abort_run(input string what);
    err_cnt++;
    $display("Timeout: %s", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic check_equal(input string name, input logic [33:0] exp, input logic [33:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Queue a result for the compare process
  task automatic expect_eq(input string name, input logic [33:0] exp, input logic [33:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  always @(posedge clk_i) begin : compare_proc
    string       nm;
    logic [33:0] e;
    logic [33:0] a;
    while (exp_q.size() > 0) begin
      nm = name_q.pop_front();
      e  = exp_q.pop_front();
      a  = act_q.pop_front();
      check_equal(nm, e, a);
    end
  end

  // Host write with AW and W together and bready low for stall cycles
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall, output logic [1:0] resp);
    int t;
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!(awready_o && wready_o)) begin
      if (t == TIMEOUT_CYC) abort_run("write address and data never accepted");
      @(negedge clk_i);
      t++;
    end
    @(posedge clk_i);
    #1;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk_i);
      #1;
    end
    bready_i = 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!bvalid_o) begin
      if (t == TIMEOUT_CYC) abort_run("write response never came");
      @(negedge clk_i);
      t++;
    end
    resp = bresp_o;
    @(posedge clk_i);
    #1;
    bready_i = 1'b0;
  endtask

  // Host read with rready low for stall cycles and {rresp, rdata} out
  task automatic axil_read(input logic [31:0] addr, input int stall, output logic [33:0] res);
    int t;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!arready_o) begin
      if (t == TIMEOUT_CYC) abort_run("read address never accepted");
      @(negedge clk_i);
      t++;
    end
    @(posedge clk_i);
    #1;
    arvalid_i = 1'b0;
    araddr_i  = ~addr; // Address may move once accepted
    for (int i = 0; i < stall; i++) begin
      @(posedge clk_i);
      #1;
    end
    rready_i = 1'b1;
    t = 0;
    @(negedge clk_i);
    while (!rvalid_o) begin
      if (t == TIMEOUT_CYC) abort_run("read data never came");
      @(negedge clk_i);
      t++;
    end
    res = {rresp_o, rdata_o};
    @(posedge clk_i);
    #1;
    rready_i = 1'b0;
  endtask

  task automatic do_write(input string name, input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, input int stall);
    logic [1:0] exp_resp;
    logic [1:0] resp;
    exp_resp = model_write(addr, data, strb);
    axil_write(addr, data, strb, stall, resp);
    expect_eq(name, {exp_resp, 32'h0}, {resp, 32'h0});
  endtask

  task automatic do_read(input string name, input logic [31:0] addr, input int stall);
    logic [33:0] exp;
    logic [33:0] res;
    exp = expect_read(addr);
    axil_read(addr, stall, res);
    expect_eq(name, exp, res);
  endtask

  // Eight cycles low with straps driven while in reset
  task automatic apply_reset();
    rst_n_i     = 1'b0;
    sw_straps_i = NUM_STRAPS'($urandom());
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i      = 1'b1;
    ref_gpio_out = '0;
    ref_status   = '0;
    ref_straps   = sw_straps_i;
  endtask

  task automatic check_reset_outputs(input string name);
    @(negedge clk_i);
    expect_eq(name, 34'h0, {11'h0, awready_o, wready_o, arready_o, bvalid_o, rvalid_o,
                            test_done_o, test_passed_o, gpio_o});
    @(posedge clk_i);
    #1;
  endtask

  // Waits for the compare process and then reports the test
  task automatic finish_test(input string name);
    int t;
    t = 0;
    while (exp_q.size() > 0) begin
      if (t == TIMEOUT_CYC) abort_run("pending checks never compared");
      @(negedge clk_i);
      t++;
    end
    $display("test %s: %0d checks, %0d errors", name, check_cnt - test_checks,
             err_cnt - test_errs);
    test_checks = check_cnt;
    test_errs   = err_cnt;
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    logic [RAM_AW-1:0] idx_q[$];
    logic [RAM_AW-1:0] idx;
    logic [31:0]       addr;
    logic [31:0]       data;
    void'($urandom(SEED));
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    awaddr_i    = '0;
    awvalid_i   = 1'b0;
    wdata_i     = '0;
    wstrb_i     = '0;
    wvalid_i    = 1'b0;
    bready_i    = 1'b0;
    araddr_i    = '0;
    arvalid_i   = 1'b0;
    rready_i    = 1'b0;
    gpio_i      = '0;
    sw_straps_i = '0;
    check_cnt   = 0;
    err_cnt     = 0;
    test_checks = 0;
    test_errs   = 0;

    apply_reset();
    check_reset_outputs("outputs after reset");
    finish_test("reset");

    // Full word first so strobed lanes land on known data
    for (int i = 0; i < RAM_TESTS; i++) begin
      idx  = RAM_AW'($urandom());
      addr = {22'h0, idx, 2'b00};
      idx_q.push_back(idx);
      do_write("ram full write", addr, $urandom(), 4'hF, 0);
      do_write("ram strobe write", addr, $urandom(), 4'($urandom()), 0);
    end
    foreach (idx_q[i]) do_read("ram read back", {22'h0, idx_q[i], 2'b00}, 0);
    finish_test("ram");

    for (int i = 0; i < 12; i++) begin
      addr = {22'h0, idx_q[i], 2'b00};
      do_write("stalled write", addr, $urandom(), 4'($urandom()), $urandom_range(6, 1));
      do_read("stalled read", addr, $urandom_range(6, 1));
    end
    finish_test("backpressure");

    data = $urandom();
    do_write("gpio out write", gpio_addr(GPIO_OUT_OFS), data, 4'hF, 0);
    expect_eq("gpio_o pins", {18'h0, data[15:0]}, {18'h0, gpio_o});
    do_read("gpio out read", gpio_addr(GPIO_OUT_OFS), 0);
    gpio_i = NUM_GPIOS'($urandom());
    repeat (3) @(posedge clk_i); // Two-flop synchronizer latency
    #1;
    do_read("gpio in read", gpio_addr(GPIO_IN_OFS), 0);
    sw_straps_i = ~ref_straps; // Pins move after the capture
    do_read("strap read", gpio_addr(GPIO_STRAP_OFS), 0);
    finish_test("gpio");

    // 0x400 aliases a written word if the decode ignored the upper bits
    addr = 32'h0000_0400 | {22'h0, idx_q[0], 2'b00};
    do_write("unmapped ram alias write", addr, $urandom(), 4'hF, 0);
    do_write("unmapped gpio write", gpio_addr(4'hC), $urandom(), 4'hF, 0);
    do_write("unmapped far write", 32'h0003_0000, $urandom(), 4'hF, 0);
    do_read("unmapped ram alias read", addr, 0);
    do_read("unmapped gpio read", gpio_addr(4'hC), 0);
    do_read("unmapped status read", STATUS_BASE + 32'h4, 0);
    do_read("ram after unmapped", {22'h0, idx_q[0], 2'b00}, 0);
    finish_test("unmapped");

    do_write("status code write", STATUS_BASE, 32'h0000_1234, 4'hF, 0);
    expect_eq("flags after plain code", {32'h0, 2'b00}, {32'h0, test_done_o, test_passed_o});
    do_read("status read", STATUS_BASE, 0);
    do_write("status passed write", STATUS_BASE, {16'h0, ST_PASSED}, 4'hF, 0);
    expect_eq("flags after passed", {32'h0, 2'b11}, {32'h0, test_done_o, test_passed_o});
    apply_reset();
    check_reset_outputs("outputs after second reset");
    do_write("status failed write", STATUS_BASE, {16'h0, ST_FAILED}, 4'hF, 0);
    expect_eq("flags after failed", {32'h0, 2'b10}, {32'h0, test_done_o, test_passed_o});
    do_read("status read after fail", STATUS_BASE, 0);
    finish_test("status");

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/tb_chip_core_checker.sv
// AXI4-Lite handshake checker
// Bound into the bus controller, watches response hold and accept blocking
`timescale 1ns/1ns
`default_nettype none

module tb_chip_core_checker (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              awready_i,
  input  logic                              wready_i,
  input  logic                              arready_i,
  input  logic                              bvalid_i,
  input  logic                              bready_i,
  input  logic                              rvalid_i,
  input  logic                              rready_i,
  input  logic [axil_pkg::AXIL_DATA_W-1:0]  rdata_i
);

  // Responses stay up until taken
  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i) else $error("bvalid dropped before bready");
  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i) else $error("rvalid dropped before rready");

  // Read word frozen under back-pressure
  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> $stable(rdata_i)) else $error("rdata moved while stalled");

  // One transaction in flight per channel
  a_no_wr_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i |-> !awready_i && !wready_i) else $error("write accepted with bvalid up");
  a_no_rd_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> !arready_i) else $error("read accepted with rvalid up");

endmodule

bind axil_bus_ctrl tb_chip_core_checker u_checker (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .awready_i (awready_o),
  .wready_i  (wready_o),
  .arready_i (arready_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .rdata_i   (rdata_o)
);

`default_nettype wire
